// ==== flist.f ====
rtl/syn_info_pkg.sv
rtl/pps_sched.sv
rtl/utc_sec_keeper.sv
rtl/info_framer.sv
rtl/tx_info_phy.sv
rtl/syn_m_info.sv
tests/tb_syn_m_info.sv

// ==== rtl/info_framer.sv ====
// seconds frame builder
`default_nettype none

module info_framer #(
	parameter int TX_DEPTH = 2
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    fire_info,
	input  syn_info_pkg::utc_sec_t   utc_sec,
	output syn_info_pkg::tx_req_s    tx_req,
	input  syn_info_pkg::tx_credit_s tx_credit
);

	import syn_info_pkg::*;

	localparam int CRD_W  = $clog2(TX_DEPTH + 1);
	localparam int IDX_W  = (INFO_BYTES > 1) ? $clog2(INFO_BYTES) : 1;
	localparam int BYTE_W = $bits(tx_byte_t);

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		DRAIN
	} state_t;

	state_t           state;
	logic [IDX_W-1:0] byte_idx;
	logic [CRD_W-1:0] credit_cnt;
	utc_sec_t         sec_lat;
	logic             issue;
	logic             last_byte;
	logic             req_valid;
	tx_byte_t         req_data;

	// one byte per cycle while credits last
	assign issue     = (state == SEND) && (credit_cnt != '0);
	assign last_byte = byte_idx == IDX_W'(INFO_BYTES - 1);

	// ----------------------------------------
	// frame FSM
	// ----------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			byte_idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (fire_info) begin
						state    <= SEND;
						byte_idx <= '0;
					end
				end
				SEND: begin
					if (issue) begin
						byte_idx <= byte_idx + 1'b1;
						if (last_byte)
							state <= DRAIN;
					end
				end
				// frame is done once the phy has every credit back
				DRAIN: begin
					if (credit_cnt == CRD_W'(TX_DEPTH))
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// snapshot so a later pps cannot tear the frame
	always_ff @(posedge clk_sys) begin
		if ((state == IDLE) && fire_info)
			sec_lat <= utc_sec;
	end

	// ----------------------------------------
	// request and credits
	// ----------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			req_valid <= 1'b0;
		else
			req_valid <= issue;
	end

	// msb first
	always_ff @(posedge clk_sys) begin
		if (issue)
			req_data <= sec_lat[(INFO_BYTES - 1 - byte_idx) * BYTE_W +: BYTE_W];
	end

	assign tx_req.valid = req_valid;
	assign tx_req.data  = req_data;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= CRD_W'(TX_DEPTH);
		end else begin
			case ({issue, tx_credit.ret})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	a_credit_max: assert property (@(posedge clk_sys) disable iff (!rst_n)
		credit_cnt <= CRD_W'(TX_DEPTH))
		else $error("credit count above TX_DEPTH");

	// idle means nothing left in flight at the phy
	a_credit_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_credit.ret |-> state != IDLE)
		else $error("credit returned while framer idle");

endmodule

`default_nettype wire

// ==== rtl/pps_sched.sv ====
// pps synchronizer and scheduler
`default_nettype none

module pps_sched #(
	parameter int INFO_DELAY = 64
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic pps,
	output logic fire_sync,
	output logic fire_info
);

	localparam int CNT_W = (INFO_DELAY > 1) ? $clog2(INFO_DELAY) : 1;

	logic [1:0]       pps_sync;
	logic             pps_prev;
	logic             fire_sync_q;
	logic             armed;
	logic [CNT_W-1:0] delay_cnt;

	// two sync flops, then the edge register
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pps_sync    <= 2'b00;
			pps_prev    <= 1'b0;
			fire_sync_q <= 1'b0;
		end else begin
			pps_sync    <= {pps_sync[0], pps};
			pps_prev    <= pps_sync[1];
			fire_sync_q <= pps_sync[1] & ~pps_prev;
		end
	end

	// ----------------------------------------
	// info delay
	// ----------------------------------------

	// a new edge reloads the count even mid-delay
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			armed     <= 1'b0;
			delay_cnt <= '0;
		end else if (fire_sync_q) begin
			armed     <= 1'b1;
			delay_cnt <= CNT_W'(INFO_DELAY - 1);
		end else if (armed) begin
			if (delay_cnt == '0)
				armed <= 1'b0;
			else
				delay_cnt <= delay_cnt - 1'b1;
		end
	end

	assign fire_sync = fire_sync_q;
	assign fire_info = armed && (delay_cnt == '0);

	// pps edges are never expected to land exactly on a pending broadcast
	a_fire_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(fire_sync && fire_info))
		else $error("fire_sync and fire_info in the same cycle");

endmodule

`default_nettype wire

// ==== rtl/syn_info_pkg.sv ====
// time sync link definitions
`default_nettype none

package syn_info_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------

	// seconds count, both GPS and local UTC
	typedef logic [31:0] utc_sec_t;

	// one payload byte on the serial line
	typedef logic [7:0] tx_byte_t;

	// clocks per serial bit
	typedef logic [19:0] bit_period_t;

	// ----------------------------------------
	// framer to phy
	// ----------------------------------------

	typedef struct packed {
		logic     valid;
		tx_byte_t data;
	} tx_req_s;

	// one credit back per finished byte
	typedef struct packed {
		logic ret;
	} tx_credit_s;

	// ----------------------------------------
	// constants
	// ----------------------------------------

	// GPS seconds must be strictly above this to be trusted
	parameter utc_sec_t GPS_VALID_MIN = 32'h00B70000;

	// bytes per broadcast frame
	parameter int INFO_BYTES = 4;

endpackage

`default_nettype wire

// ==== rtl/syn_m_info.sv ====
// time sync master top
`default_nettype none

module syn_m_info #(
	parameter syn_info_pkg::bit_period_t BIT_PERIOD = 20'd10,
	parameter int                        INFO_DELAY = 64,
	parameter int                        TX_DEPTH   = 2
) (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  pps,
	input  syn_info_pkg::utc_sec_t utc_sec_gps,
	output logic                  tx_info,
	output syn_info_pkg::utc_sec_t utc_sec
);

	import syn_info_pkg::*;

	logic       fire_sync;
	logic       fire_info;
	tx_req_s    tx_req;
	tx_credit_s tx_credit;

	// ----------------------------------------
	// pulse path
	// ----------------------------------------

	pps_sched #(
		.INFO_DELAY(INFO_DELAY)
	) u_pps_sched (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.pps      (pps),
		.fire_sync(fire_sync),
		.fire_info(fire_info)
	);

	utc_sec_keeper u_utc_sec_keeper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.fire_sync  (fire_sync),
		.utc_sec_gps(utc_sec_gps),
		.utc_sec    (utc_sec)
	);

	// ----------------------------------------
	// broadcast path
	// ----------------------------------------

	// credit count tracks the phy buffer depth
	info_framer #(
		.TX_DEPTH(TX_DEPTH)
	) u_info_framer (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.fire_info(fire_info),
		.utc_sec  (utc_sec),
		.tx_req   (tx_req),
		.tx_credit(tx_credit)
	);

	tx_info_phy #(
		.BIT_PERIOD(BIT_PERIOD),
		.TX_DEPTH  (TX_DEPTH)
	) u_tx_info_phy (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.tx_req   (tx_req),
		.tx_credit(tx_credit),
		.tx       (tx_info)
	);

endmodule

`default_nettype wire

// ==== rtl/tx_info_phy.sv ====
// serial byte transmitter
`default_nettype none

module tx_info_phy #(
	parameter syn_info_pkg::bit_period_t BIT_PERIOD = 20'd10,
	parameter int                        TX_DEPTH   = 2
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  syn_info_pkg::tx_req_s    tx_req,
	output syn_info_pkg::tx_credit_s tx_credit,
	output logic                    tx
);

	import syn_info_pkg::*;

	localparam int PTR_W      = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
	localparam int CNT_W      = $clog2(TX_DEPTH + 1);
	localparam int FRAME_BITS = $bits(tx_byte_t) + 2;
	localparam int BIDX_W     = $clog2(FRAME_BITS);

	tx_byte_t            fifo_mem [TX_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    fifo_cnt;
	logic                push;
	logic                pop;
	logic                busy;
	bit_period_t         bit_cnt;
	logic [BIDX_W-1:0]   bit_idx;
	logic [FRAME_BITS-1:0] frame_sh;
	logic                bit_end;
	logic                byte_done;
	logic                credit_q;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(TX_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// ----------------------------------------
	// byte FIFO
	// ----------------------------------------

	assign push = tx_req.valid;

	always_ff @(posedge clk_sys) begin
		if (push)
			fifo_mem[wr_ptr] <= tx_req.data;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
		end
	end

	// ----------------------------------------
	// serializer
	// ----------------------------------------

	assign bit_end   = busy && (bit_cnt == BIT_PERIOD - bit_period_t'(1));
	assign byte_done = bit_end && (bit_idx == BIDX_W'(FRAME_BITS - 1));
	// reload right at the stop bit end, so no idle gap between bytes
	assign pop       = (!busy || byte_done) && (fifo_cnt != '0);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			bit_cnt  <= '0;
			bit_idx  <= '0;
			frame_sh <= '1;
			credit_q <= 1'b0;
		end else begin
			credit_q <= byte_done;
			if (pop) begin
				busy     <= 1'b1;
				bit_cnt  <= '0;
				bit_idx  <= '0;
				// stop, data lsb first, start
				frame_sh <= {1'b1, fifo_mem[rd_ptr], 1'b0};
			end else if (byte_done) begin
				busy     <= 1'b0;
				bit_cnt  <= '0;
				frame_sh <= '1;
			end else if (bit_end) begin
				bit_cnt  <= '0;
				bit_idx  <= bit_idx + 1'b1;
				frame_sh <= {1'b1, frame_sh[FRAME_BITS-1:1]};
			end else if (busy) begin
				bit_cnt <= bit_cnt + bit_period_t'(1);
			end
		end
	end

	assign tx            = frame_sh[0];
	assign tx_credit.ret = credit_q;

	// the framer's credits must keep it from overrunning the FIFO
	a_no_overflow: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_req.valid |-> fifo_cnt != CNT_W'(TX_DEPTH))
		else $error("byte received with FIFO full");

endmodule

`default_nettype wire

// ==== rtl/utc_sec_keeper.sv ====
// UTC seconds keeper
`default_nettype none

module utc_sec_keeper (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  fire_sync,
	input  syn_info_pkg::utc_sec_t utc_sec_gps,
	output syn_info_pkg::utc_sec_t utc_sec
);

	import syn_info_pkg::*;

	utc_sec_t gps_old;
	logic     gps_plausible;
	logic     gps_fresh;
	logic     reload;

	// ----------------------------------------
	// GPS qualification
	// ----------------------------------------

	// value seen at the previous pulse
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			gps_old <= '0;
		else if (fire_sync)
			gps_old <= utc_sec_gps;
	end

	assign gps_plausible = utc_sec_gps > GPS_VALID_MIN;
	assign gps_fresh     = utc_sec_gps != gps_old;

	// stale or implausible GPS falls back to free running
	assign reload = gps_plausible && gps_fresh;

	// ----------------------------------------
	// seconds register
	// ----------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			utc_sec <= '0;
		end else if (fire_sync) begin
			if (reload)
				// one second of link delay added on load
				utc_sec <= utc_sec_gps + utc_sec_t'(1);
			else
				utc_sec <= utc_sec + utc_sec_t'(1);
		end
	end

	// GPS value has to be resolved whenever it is sampled
	a_gps_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_sync |-> !$isunknown(utc_sec_gps))
		else $error("utc_sec_gps unknown at fire_sync");

endmodule

`default_nettype wire

// ==== tests/tb_syn_m_info.sv ====
// time sync master testbench
`default_nettype none

module tb_syn_m_info;

	import syn_info_pkg::*;

	localparam int BIT_PERIOD = 10;
	localparam int INFO_DELAY = 64;
	localparam int TX_DEPTH   = 2;
	localparam int NUM_ROWS   = 8;

	// one table row: GPS input, expected seconds, extra pps mid-frame
	typedef struct packed {
		utc_sec_t gps;
		utc_sec_t exp_sec;
		logic     mid_pps;
	} row_s;

	logic     clk_sys;
	logic     rst_n;
	logic     pps;
	utc_sec_t utc_sec_gps;
	logic     tx_info;
	utc_sec_t utc_sec;

	row_s     rows [NUM_ROWS];
	utc_sec_t prev_sec;

	syn_m_info #(
		.BIT_PERIOD(bit_period_t'(BIT_PERIOD)),
		.INFO_DELAY(INFO_DELAY),
		.TX_DEPTH  (TX_DEPTH)
	) u_dut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.pps        (pps),
		.utc_sec_gps(utc_sec_gps),
		.tx_info    (tx_info),
		.utc_sec    (utc_sec)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s (got %h, expected %h)", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "run stopped on first error");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timed out at time %0t while waiting for %s", $time, what);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped on timeout");
	endtask

	// pps high for two clock cycles
	task automatic pulse_pps();
		@(negedge clk_sys);
		pps = 1'b1;
		repeat (2) @(negedge clk_sys);
		pps = 1'b0;
	endtask

	task automatic wait_sec_change(input utc_sec_t old_sec);
		int n;
		n = 0;
		while (utc_sec === old_sec) begin
			@(negedge clk_sys);
			n++;
			if (n > 16)
				fail_timeout("utc_sec to update after pps");
		end
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk_sys);
			check_value(tx_info, 1'b1, "idle serial line");
		end
	endtask

	// start detect, then sample each bit near its middle
	task automatic recv_byte(input int limit, output tx_byte_t data, output int gap);
		int n;
		data = '0;
		n = 0;
		while (tx_info !== 1'b0) begin
			@(negedge clk_sys);
			n++;
			if (n > limit)
				fail_timeout("serial start bit");
		end
		gap = n;
		repeat (BIT_PERIOD / 2) @(negedge clk_sys);
		check_value(tx_info, 1'b0, "start bit");
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_PERIOD) @(negedge clk_sys);
			data[i] = tx_info;
		end
		repeat (BIT_PERIOD) @(negedge clk_sys);
		check_value(tx_info, 1'b1, "stop bit");
	endtask

	task automatic recv_frame(input utc_sec_t exp_sec);
		tx_byte_t data;
		int       gap;
		int       limit;
		for (int b = 0; b < INFO_BYTES; b++) begin
			limit = (b == 0) ? 4 * INFO_DELAY : BIT_PERIOD;
			recv_byte(limit, data, gap);
			// back-to-back bytes: next start edge one bit after the stop sample point
			if (b > 0)
				check_value(gap, BIT_PERIOD - BIT_PERIOD / 2, $sformatf("gap before byte %0d", b));
			check_value(data, exp_sec[8 * (INFO_BYTES - 1 - b) +: 8],
				$sformatf("frame byte %0d", b));
		end
		check_idle(2 * BIT_PERIOD);
	endtask

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------

	task automatic load_table();
		// at or below the limit, so free running
		rows[0] = '{gps: 32'h0000_0000, exp_sec: 32'h0000_0001, mid_pps: 1'b0};
		rows[1] = '{gps: 32'h00B7_0000, exp_sec: 32'h0000_0002, mid_pps: 1'b0};
		// fresh and plausible loads gps + 1, the repeat only increments
		rows[2] = '{gps: 32'h00B7_0001, exp_sec: 32'h00B7_0002, mid_pps: 1'b0};
		rows[3] = '{gps: 32'h00B7_0001, exp_sec: 32'h00B7_0003, mid_pps: 1'b0};
		rows[4] = '{gps: 32'h1234_5678, exp_sec: 32'h1234_5679, mid_pps: 1'b1};
		// follows the extra pps of the previous row
		rows[5] = '{gps: 32'h0000_0010, exp_sec: 32'h1234_567B, mid_pps: 1'b0};
		rows[6] = '{gps: 32'hA5C3_0FF0, exp_sec: 32'hA5C3_0FF1, mid_pps: 1'b0};
		rows[7] = '{gps: 32'hA5C3_0FF0, exp_sec: 32'hA5C3_0FF2, mid_pps: 1'b0};
	endtask

	initial begin
		rst_n       = 1'b0;
		pps         = 1'b0;
		utc_sec_gps = '0;
		prev_sec    = '0;
		load_table();
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		// quiet line and zero seconds before any pps
		repeat (2 * BIT_PERIOD) begin
			@(negedge clk_sys);
			check_value(tx_info, 1'b1, "tx_info after reset");
			check_value(utc_sec, 32'd0, "utc_sec after reset");
		end

		for (int r = 0; r < NUM_ROWS; r++) begin
			utc_sec_gps = rows[r].gps;
			pulse_pps();
			wait_sec_change(prev_sec);
			check_value(utc_sec, rows[r].exp_sec, $sformatf("utc_sec for row %0d", r));
			if (rows[r].mid_pps) begin
				// second pps lands while byte 0 is on the line
				fork
					recv_frame(rows[r].exp_sec);
					begin
						repeat (120) @(negedge clk_sys);
						pulse_pps();
					end
				join
				// stale GPS, so the extra pps only increments
				check_value(utc_sec, rows[r].exp_sec + 32'd1,
					$sformatf("utc_sec after mid-frame pps, row %0d", r));
				prev_sec = rows[r].exp_sec + 32'd1;
			end else begin
				recv_frame(rows[r].exp_sec);
				prev_sec = rows[r].exp_sec;
			end
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire
